//--- design/cpu_pkg.sv
//################################################
// Shared constants for the CPU instruction front end.
// Holds default widths, instruction field positions,
// the NOP word and the load opcode. Referenced with
// scoped names by the design and the testbench.
//################################################

package cpu_pkg;

	// Default widths, overridden from the top level
	localparam int BITS = 16;
	localparam int ADDRESS_BITS = 8;

	// The all-zero word is the NOP
	localparam logic [BITS - 1:0] NOP_WORD = '0;

	localparam logic [3:0] OPC_LOAD = 4'h4;

	// Instruction fields: opcode, destination, two sources
	localparam int OPC_MSB = 15;
	localparam int OPC_LSB = 12;
	localparam int RD_MSB = 11;
	localparam int RD_LSB = 8;
	localparam int RA_MSB = 7;
	localparam int RA_LSB = 4;
	localparam int RB_MSB = 3;
	localparam int RB_LSB = 0;

endpackage

//--- design/program_memory.sv
//################################################
// Instruction memory with one write and one read port.
// The write port is filled by the testbench before run.
// Read data appears one clock after read_en and holds
// its value while read_en is low.
//################################################

module program_memory #(
	parameter int BITS = 16,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                      CLK,

	input  logic                      load_en,
	input  logic [ADDRESS_BITS - 1:0] load_address,
	input  logic [BITS - 1:0]         load_data,

	input  logic                      read_en,
	input  logic [ADDRESS_BITS - 1:0] read_address,
	output logic [BITS - 1:0]         memory_data
);

	localparam int DEPTH = 1 << ADDRESS_BITS;

	logic [BITS - 1:0] mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (load_en) begin
			mem[load_address] <= load_data;
		end
	end

	// Registered read, data only moves when a read is issued
	always_ff @(posedge CLK) begin
		if (read_en) begin
			memory_data <= mem[read_address];
		end
	end

	// Loading and fetching the same word at once gives stale data
	a_no_read_write_collision: assert property (@(posedge CLK)
		!(load_en && read_en && load_address == read_address))
		else $error("program_memory: read and write to the same address");

endmodule

//--- design/fetch_unit.sv
//################################################
// Program counter and read request generation.
// pc is the address of the word that stage0 takes next.
// During a start mask the word at pc is read again,
// otherwise the next word is read and pc increments.
//################################################

module fetch_unit #(
	parameter int ADDRESS_BITS = 8
) (
	input  logic                      CLK,
	input  logic                      RSTb,

	input  logic                      advance,
	input  logic                      masked,

	output logic                      read_en,
	output logic [ADDRESS_BITS - 1:0] read_address
);

	logic [ADDRESS_BITS - 1:0] pc;
	logic [ADDRESS_BITS - 1:0] pc_plus_one;

	assign pc_plus_one = pc + 1'b1;

	// One read per pipeline advance
	assign read_en = advance;

	// Re-read on a mask cycle so memory_data keeps the word at pc
	assign read_address = masked ? pc : pc_plus_one;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc <= '0;
		end else if (advance && !masked) begin
			// stage0 takes the word at pc, so move on
			pc <= pc_plus_one;
		end
	end

endmodule

//--- design/cpu_pipeline.sv
//################################################
// Five-stage instruction pipeline: fetch, decode,
// execute, memory and write back. Masks one cycle with
// a NOP at every start of run and inserts a bubble into
// execute when the hazard detector raises stall.
//################################################

module cpu_pipeline #(
	parameter int BITS = 16
) (
	input  logic              CLK,
	input  logic              RSTb,

	input  logic              run,
	input  logic              stall,
	input  logic [BITS - 1:0] memory_data,

	output logic              advance,
	output logic              masked,

	output logic [BITS - 1:0] stage0,
	output logic [BITS - 1:0] stage1,
	output logic [BITS - 1:0] stage2,
	output logic [BITS - 1:0] stage3,
	output logic [BITS - 1:0] stage4
);

	localparam logic [BITS - 1:0] NOP = BITS'(cpu_pkg::NOP_WORD);

	// Number of NOP cycles after a rising run
	localparam logic [1:0] MASK_CYCLES = 2'd1;

	logic       prev_run;
	logic       running;
	logic [1:0] mask_count;

	// Pipeline only moves once run has been seen on two edges
	assign running = run && prev_run;
	assign advance = running && !stall;
	assign masked = (mask_count != 2'd0);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			prev_run <= 1'b0;
			mask_count <= 2'd0;
		end else begin
			prev_run <= run;
			if (run && !prev_run) begin
				mask_count <= MASK_CYCLES;
			end else if (advance && masked) begin
				// Count down only when a NOP was really taken
				mask_count <= mask_count - 2'd1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stage0 <= NOP;
			stage1 <= NOP;
			stage2 <= NOP;
			stage3 <= NOP;
			stage4 <= NOP;
		end else if (advance) begin
			stage0 <= masked ? NOP : memory_data;
			stage1 <= stage0;
			stage2 <= stage1;
			stage3 <= stage2;
			stage4 <= stage3;
		end else if (running && stall) begin
			// Fetch and decode hold, bubble into execute
			stage2 <= NOP;
			stage3 <= stage2;
			stage4 <= stage3;
		end
	end

	// Front stages and the fetched word must not be lost across a stall
	a_stall_holds_front: assert property (@(posedge CLK) disable iff (!RSTb)
		stall |=> ($stable(stage0) && $stable(stage1) && $stable(memory_data)))
		else $error("cpu_pipeline: front stages or fetched word changed during stall");

endmodule

//--- design/hazard_detector.sv
//################################################
// Load-use hazard detection between decode and execute.
// Raises stall when execute holds a load whose nonzero
// destination is a source of the decode instruction.
// CLK and RSTb only clock the assertion.
//################################################

module hazard_detector (
	input  logic                         CLK,
	input  logic                         RSTb,

	input  logic [cpu_pkg::BITS - 1:0]   stage1,
	input  logic [cpu_pkg::BITS - 1:0]   stage2,

	output logic                         stall
);

	logic [cpu_pkg::OPC_MSB - cpu_pkg::OPC_LSB:0] ex_opcode;
	logic [cpu_pkg::RD_MSB - cpu_pkg::RD_LSB:0]   ex_rd;
	logic [cpu_pkg::RA_MSB - cpu_pkg::RA_LSB:0]   de_ra;
	logic [cpu_pkg::RB_MSB - cpu_pkg::RB_LSB:0]   de_rb;
	logic                                         ex_is_load;
	logic                                         uses_rd;

	assign ex_opcode = stage2[cpu_pkg::OPC_MSB:cpu_pkg::OPC_LSB];
	assign ex_rd = stage2[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
	assign de_ra = stage1[cpu_pkg::RA_MSB:cpu_pkg::RA_LSB];
	assign de_rb = stage1[cpu_pkg::RB_MSB:cpu_pkg::RB_LSB];

	assign ex_is_load = (ex_opcode == cpu_pkg::OPC_LOAD);

	// r0 is never a hazard source
	assign uses_rd = (ex_rd != '0) && (ex_rd == de_ra || ex_rd == de_rb);

	assign stall = ex_is_load && uses_rd;

	// The bubble clears execute, so a stall that the pipeline acted
	// on lasts one cycle; it only persists while everything holds
	a_stall_one_cycle: assert property (@(posedge CLK) disable iff (!RSTb)
		stall ##1 stall |-> ($stable(stage1) && $stable(stage2)))
		else $error("hazard_detector: stall held across a moving pipeline");

endmodule

//--- design/cpu_frontend.sv
//################################################
// Top level of the CPU instruction front end.
// Connects program memory, fetch unit, pipeline and
// hazard detector. The testbench loads the program
// memory and then drives run.
//################################################

module cpu_frontend #(
	parameter int BITS = cpu_pkg::BITS,
	parameter int ADDRESS_BITS = cpu_pkg::ADDRESS_BITS
) (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  logic                      run,

	input  logic                      load_en,
	input  logic [ADDRESS_BITS - 1:0] load_address,
	input  logic [BITS - 1:0]         load_data,

	output logic [BITS - 1:0]         stage0,
	output logic [BITS - 1:0]         stage1,
	output logic [BITS - 1:0]         stage2,
	output logic [BITS - 1:0]         stage3,
	output logic [BITS - 1:0]         stage4,
	output logic                      stall
);

	logic                      advance;
	logic                      masked;
	logic                      read_en;
	logic [ADDRESS_BITS - 1:0] read_address;
	logic [BITS - 1:0]         memory_data;

	program_memory #(
		.BITS         (BITS),
		.ADDRESS_BITS (ADDRESS_BITS)
	) u_program_memory (
		.CLK          (CLK),
		.load_en      (load_en),
		.load_address (load_address),
		.load_data    (load_data),
		.read_en      (read_en),
		.read_address (read_address),
		.memory_data  (memory_data)
	);

	fetch_unit #(
		.ADDRESS_BITS (ADDRESS_BITS)
	) u_fetch_unit (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.advance      (advance),
		.masked       (masked),
		.read_en      (read_en),
		.read_address (read_address)
	);

	cpu_pipeline #(
		.BITS (BITS)
	) u_cpu_pipeline (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.run         (run),
		.stall       (stall),
		.memory_data (memory_data),
		.advance     (advance),
		.masked      (masked),
		.stage0      (stage0),
		.stage1      (stage1),
		.stage2      (stage2),
		.stage3      (stage3),
		.stage4      (stage4)
	);

	hazard_detector u_hazard_detector (
		.CLK    (CLK),
		.RSTb   (RSTb),
		.stage1 (stage1),
		.stage2 (stage2),
		.stall  (stall)
	);

endmodule

//--- verification/tb_clock.sv
//################################################
// Clock and reset source for the testbench.
// Period of 100, reset low for 4 cycles at start and
// again for 4 cycles after each reset_request pulse.
//################################################

module tb_clock (
	input  logic reset_request,
	output logic CLK,
	output logic RSTb
);

	int count = 0;

	initial begin
		CLK = 1'b0;
		RSTb = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		if (reset_request) begin
			count <= 0;
		end else if (count < 3) begin
			count <= count + 1;
		end
		RSTb <= !reset_request && (count == 3);
	end

endmodule

//--- verification/tb_checker.sv
//################################################
// Monitor for the CPU front end. Captures the program
// from the load port, predicts the stage4 word stream
// and the stall count, and compares at each falling edge.
//################################################

module tb_checker #(
	parameter int BITS = 16,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  logic                      run,
	input  logic                      load_en,
	input  logic [ADDRESS_BITS - 1:0] load_address,
	input  logic [BITS - 1:0]         load_data,
	input  logic [BITS - 1:0]         stage0,
	input  logic [BITS - 1:0]         stage1,
	input  logic [BITS - 1:0]         stage2,
	input  logic [BITS - 1:0]         stage3,
	input  logic [BITS - 1:0]         stage4,
	input  logic                      stall,
	output int                        error_count,
	output logic                      done
);

	localparam int DEPTH = 1 << ADDRESS_BITS;
	localparam logic [BITS - 1:0] NOP = '0;

	logic [BITS - 1:0] program_words [DEPTH];
	logic [BITS - 1:0] expected [$];
	logic [BITS - 1:0] held [5];
	logic [BITS - 1:0] now_stages [5];

	int  edge_count = 0;
	int  first_edge;
	int  predicted_stalls;
	int  stall_count;
	int  restarts;
	bit  last_run;
	bit  pending;
	bit  hold;
	bit  stall_prev;
	bit  after_reset;
	bit  first_start;
	bit  seen0;
	bit  seen4;

	initial begin
		error_count = 0;
		done = 1'b0;
	end

	// Older word is a load whose nonzero destination the younger one reads
	function automatic bit is_load_use(input logic [BITS - 1:0] older,
			input logic [BITS - 1:0] younger);
		logic [3:0] rd;
		rd = older[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
		return older[cpu_pkg::OPC_MSB:cpu_pkg::OPC_LSB] == cpu_pkg::OPC_LOAD && rd != 4'd0
			&& (rd == younger[cpu_pkg::RA_MSB:cpu_pkg::RA_LSB]
			|| rd == younger[cpu_pkg::RB_MSB:cpu_pkg::RB_LSB]);
	endfunction

	// Reference stream at stage4, one bubble behind each load-use load
	function automatic int compute_expected();
		int n;
		int bubbles;
		n = 0;
		bubbles = 0;
		expected.delete();
		while (n < DEPTH && program_words[n] != NOP) begin
			n++;
		end
		for (int i = 0; i < n; i++) begin
			expected.push_back(program_words[i]);
			if (i + 1 < n && is_load_use(program_words[i], program_words[i + 1])) begin
				expected.push_back(NOP);
				bubbles++;
			end
		end
		return bubbles;
	endfunction

	always @(posedge CLK) begin
		edge_count++;
		if (load_en) begin
			program_words[load_address] = load_data;
		end
	end

	always @(negedge CLK) begin
		now_stages = '{stage0, stage1, stage2, stage3, stage4};
		if (!RSTb) begin
			last_run = 1'b0;
			pending = 1'b0;
			hold = 1'b0;
			stall_prev = 1'b0;
			after_reset = 1'b1;
			first_start = 1'b1;
			seen0 = 1'b0;
			seen4 = 1'b0;
			restarts = 0;
			stall_count = 0;
			expected.delete();
			done = 1'b0;
		end else begin
			if (after_reset) begin
				for (int s = 0; s < 5; s++) begin
					if (now_stages[s] != NOP) begin
						$display("[ERROR] %0t stage%0d after reset: expected %h, got %h",
							$time, s, NOP, now_stages[s]);
						error_count++;
					end
				end
				if (stall) begin
					$display("[ERROR] %0t stall after reset: expected 0, got %b",
						$time, stall);
					error_count++;
				end
				after_reset = 1'b0;
			end
			// Pipeline did not move on the last edge
			if (hold) begin
				for (int s = 0; s < 5; s++) begin
					if (now_stages[s] != held[s]) begin
						$display("[ERROR] %0t stage%0d: expected %h, got %h",
							$time, s, held[s], now_stages[s]);
						error_count++;
					end
				end
			end
			if (!first_start && !seen0 && stage0 != NOP) begin
				seen0 = 1'b1;
				if (edge_count != first_edge + 2) begin
					$display("%0t: first word reached stage0 at edge %0d, not %0d",
						$time, edge_count - first_edge + 1, 3);
					error_count++;
				end
				if (stage0 != program_words[0]) begin
					$display("[ERROR] %0t stage0: expected %h, got %h",
						$time, program_words[0], stage0);
					error_count++;
				end
			end
			if (pending && !done && !first_start) begin
				if (stage4 != NOP) begin
					if (!seen4 && edge_count != first_edge + 6) begin
						$display("%0t: first word reached stage4 at edge %0d, not %0d",
							$time, edge_count - first_edge + 1, 7);
						error_count++;
					end
					seen4 = 1'b1;
					if (expected.size() == 0) begin
						$display("%0t: stage4 shows a word beyond the program", $time);
						error_count++;
					end else begin
						if (expected[0] != stage4) begin
							$display("[ERROR] %0t stage4: expected %h, got %h",
								$time, expected[0], stage4);
							error_count++;
						end
						void'(expected.pop_front());
					end
				end else if (seen4 && expected.size() > 0) begin
					if (expected[0] == NOP) begin
						void'(expected.pop_front());
					end else if (restarts > 0) begin
						// Mask NOP from a restart
						restarts--;
					end else begin
						$display("[ERROR] %0t stage4: expected %h, got %h",
							$time, expected[0], stage4);
						error_count++;
					end
				end
				if (seen4 && expected.size() == 0) begin
					if (stall_count != predicted_stalls) begin
						$display("[ERROR] %0t stall count: expected %0d, got %0d",
							$time, predicted_stalls, stall_count);
						error_count++;
					end
					if (restarts != 0) begin
						$display("%0t: %0d restart mask NOPs never reached stage4",
							$time, restarts);
						error_count++;
					end
					done = 1'b1;
				end
			end
			// Look ahead to the next rising edge
			if (run && !last_run) begin
				if (first_start) begin
					predicted_stalls = compute_expected();
					first_edge = edge_count + 1;
					first_start = 1'b0;
				end else begin
					restarts++;
				end
			end
			pending = run && last_run;
			if (pending && stall) begin
				stall_count++;
				if (stall_prev) begin
					$display("%0t: stall was high on two consecutive cycles", $time);
					error_count++;
				end
			end
			stall_prev = pending && stall;
			last_run = run;
			held = now_stages;
			hold = !pending;
		end
	end

endmodule

//--- verification/tb_frontend.sv
//################################################
// Testbench top for the CPU front end. Loads a random
// program with load-use pairs and runs it, then resets
// and runs a hazard-free program with two pauses.
//################################################

module tb_frontend;

	localparam int BITS = cpu_pkg::BITS;
	localparam int ADDRESS_BITS = cpu_pkg::ADDRESS_BITS;
	localparam int DEPTH = 1 << ADDRESS_BITS;
	localparam int PROGRAM_WORDS = 48;
	localparam int PROGRAMS = 2;
	localparam int TIMEOUT_CYCLES = 20 * PROGRAM_WORDS * PROGRAMS + 100;

	logic                      CLK;
	logic                      RSTb;
	logic                      reset_request;
	logic                      run;
	logic                      load_en;
	logic [ADDRESS_BITS - 1:0] load_address;
	logic [BITS - 1:0]         load_data;
	logic [BITS - 1:0]         stage0;
	logic [BITS - 1:0]         stage1;
	logic [BITS - 1:0]         stage2;
	logic [BITS - 1:0]         stage3;
	logic [BITS - 1:0]         stage4;
	logic                      stall;
	int                        error_count;
	logic                      done;
	int                        seed = 65;

	tb_clock u_clock (
		.reset_request (reset_request),
		.CLK           (CLK),
		.RSTb          (RSTb)
	);

	cpu_frontend #(
		.BITS         (BITS),
		.ADDRESS_BITS (ADDRESS_BITS)
	) dut (
		.CLK (CLK), .RSTb (RSTb), .run (run),
		.load_en (load_en), .load_address (load_address), .load_data (load_data),
		.stage0 (stage0), .stage1 (stage1), .stage2 (stage2),
		.stage3 (stage3), .stage4 (stage4), .stall (stall)
	);

	tb_checker #(
		.BITS         (BITS),
		.ADDRESS_BITS (ADDRESS_BITS)
	) u_checker (
		.CLK (CLK), .RSTb (RSTb), .run (run),
		.load_en (load_en), .load_address (load_address), .load_data (load_data),
		.stage0 (stage0), .stage1 (stage1), .stage2 (stage2),
		.stage3 (stage3), .stage4 (stage4), .stall (stall),
		.error_count (error_count), .done (done)
	);

	// Nonzero random word, never a load when loads are not allowed
	function automatic logic [BITS - 1:0] random_word(input bit allow_load);
		logic [BITS - 1:0] word;
		word = BITS'($random(seed));
		if (!allow_load && word[cpu_pkg::OPC_MSB:cpu_pkg::OPC_LSB] == cpu_pkg::OPC_LOAD) begin
			word[cpu_pkg::OPC_MSB:cpu_pkg::OPC_LSB] = 4'h5;
		end
		if (word == '0) begin
			word = 16'h1001;
		end
		return word;
	endfunction

	task automatic load_program(input bit with_hazards);
		logic [BITS - 1:0] word;
		logic [3:0]        rd;
		rd = 4'd1;
		for (int i = 0; i < DEPTH; i++) begin
			if (i >= PROGRAM_WORDS) begin
				word = cpu_pkg::NOP_WORD;
			end else if (with_hazards && i % 6 == 0) begin
				rd = 4'($unsigned($random(seed)) % 15 + 1);
				word = {cpu_pkg::OPC_LOAD, rd, 8'($random(seed))};
			end else if (with_hazards && i % 6 == 1) begin
				// Reads the destination of the load just before
				word = {4'h1, 4'($random(seed)), rd, 4'($random(seed))};
			end else begin
				word = random_word(with_hazards);
			end
			@(posedge CLK);
			load_en <= 1'b1;
			load_address <= ADDRESS_BITS'(i);
			load_data <= word;
		end
		@(posedge CLK);
		load_en <= 1'b0;
	endtask

	task automatic run_program(input bit with_pauses);
		@(posedge CLK);
		run <= 1'b1;
		if (with_pauses) begin
			repeat (2) begin
				repeat (10 + $unsigned($random(seed)) % 5) @(posedge CLK);
				run <= 1'b0;
				repeat (1 + $unsigned($random(seed)) % 4) @(posedge CLK);
				run <= 1'b1;
			end
		end
		wait (done);
		@(posedge CLK);
		run <= 1'b0;
		repeat (2) @(posedge CLK);
	endtask

	initial begin
		reset_request = 1'b0;
		run = 1'b0;
		load_en = 1'b0;
		load_address = '0;
		load_data = '0;
		wait (RSTb);
		load_program(1'b1);
		run_program(1'b0);
		@(posedge CLK);
		reset_request <= 1'b1;
		@(posedge CLK);
		reset_request <= 1'b0;
		wait (!RSTb);
		wait (RSTb);
		load_program(1'b0);
		run_program(1'b1);
		$display("Closing: checker errors %0d, timeouts 0", error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("Timeout: the programs did not complete in %0d cycles", TIMEOUT_CYCLES);
		$display("Closing: checker errors %0d, timeouts 1", error_count);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- build.f
design/cpu_pkg.sv
design/program_memory.sv
design/fetch_unit.sv
design/cpu_pipeline.sv
design/hazard_detector.sv
design/cpu_frontend.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_frontend.sv

//--- Bender.yml
package:
  name: cpu_frontend

sources:
  - files:
      - design/cpu_pkg.sv
      - design/program_memory.sv
      - design/fetch_unit.sv
      - design/cpu_pipeline.sv
      - design/hazard_detector.sv
      - design/cpu_frontend.sv
  - target: simulation
    files:
      - verification/tb_clock.sv
      - verification/tb_checker.sv
      - verification/tb_frontend.sv
